/* hw/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_addr_t;

	localparam reg_addr_t REG_SP = 4'd8;
	localparam reg_addr_t REG_T = 4'd9;
	localparam reg_addr_t REG_IH = 4'd10;
	localparam reg_addr_t REG_NONE = 4'd15;
	localparam reg_addr_t REG_COUNT = 4'd11;    // R0..R7, SP, T, IH

	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_AND = 4'b0001,
		ALU_OR = 4'b0010,
		ALU_SLL = 4'b0011,
		ALU_SRA = 4'b0101,
		ALU_SUB = 4'b0110,
		ALU_EQUAL = 4'b0111,
		ALU_MOVE = 4'b1001,
		ALU_NONE = 4'b1111
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NONE = 3'b000,
		SEL_REG_REG = 3'b001,
		SEL_REG_IMM = 3'b010,
		SEL_REG = 3'b011,
		SEL_IMM = 3'b100
	} operand_sel_e;

	typedef enum logic [4:0] {
		OP_NOP = 5'b00001,
		OP_SHIFT = 5'b00110,
		OP_ADDIU3 = 5'b01000,
		OP_ADDIU = 5'b01001,
		OP_SP = 5'b01100,          // ADDSP, MTSP
		OP_LI = 5'b01101,
		OP_CMPI = 5'b01110,
		OP_ADDSUBU = 5'b11100,
		OP_RR = 5'b11101,          // AND, OR, CMP, MFPC
		OP_IH = 5'b11110
	} op_major_e;

	////////////////////////////////////////////////////////////////////
	// Function fields below the major opcode

	localparam logic [2:0] FN_ADDSP = 3'b011;   // instr[10:8]
	localparam logic [2:0] FN_MTSP = 3'b100;
	localparam logic [1:0] FN_ADDU = 2'b01;     // instr[1:0]
	localparam logic [1:0] FN_SUBU = 2'b11;
	localparam logic [4:0] FN_AND = 5'b01100;   // instr[4:0]
	localparam logic [4:0] FN_CMP = 5'b01010;
	localparam logic [4:0] FN_OR = 5'b01101;
	localparam logic [4:0] FN_PC_GRP = 5'b00000;
	localparam logic [2:0] FN_MFPC = 3'b010;    // instr[7:5]
	localparam logic FN_MFIH = 1'b0;            // instr[0]
	localparam logic FN_MTIH = 1'b1;
	localparam logic [1:0] FN_SLL = 2'b00;      // instr[1:0]
	localparam logic [1:0] FN_SRA = 2'b11;

	typedef enum logic {
		FETCH_IDLE = 1'b0,
		FETCH_BUSY = 1'b1
	} fetch_state_e;

	typedef struct packed {
		logic valid;
		word_t instr;
		word_t next_pc;
	} fetch_t;

	typedef struct packed {
		logic valid;
		alu_op_e alu_op;
		operand_sel_e sel;
		reg_addr_t reg_a;
		reg_addr_t reg_b;
		word_t imm;
		logic reg_write;
		reg_addr_t dest;
	} decoded_t;

	typedef struct packed {
		logic valid;
		reg_addr_t dest;
		word_t data;
	} retire_t;

endpackage

/* hw/fetch_stage.sv */
module fetch_stage #(
	parameter int WB_ADDR_WIDTH = 16,
	parameter int unsigned RESET_PC = 0
) (
	input logic clk,
	input logic arst_n,
	input logic run,
	output logic wb_cyc,
	output logic wb_stb,
	output logic [WB_ADDR_WIDTH-1:0] wb_adr,
	input cpu_pkg::word_t wb_dat_i,
	input logic wb_ack,
	output cpu_pkg::fetch_t fetch
);

	localparam logic [WB_ADDR_WIDTH-1:0] PC_START = WB_ADDR_WIDTH'(RESET_PC);

	cpu_pkg::fetch_state_e state;
	logic [WB_ADDR_WIDTH-1:0] pc;
	logic [WB_ADDR_WIDTH-1:0] pc_inc;
	logic xfer_done;
	logic valid_q;
	cpu_pkg::word_t instr_q;
	cpu_pkg::word_t next_pc_q;

	assign pc_inc = pc + 1'b1;
	assign wb_cyc = (state == cpu_pkg::FETCH_BUSY);
	assign wb_stb = wb_cyc;                     // Single-beat reads only
	assign wb_adr = pc;
	assign xfer_done = wb_stb && wb_ack;

	////////////////////////////////////////////////////////////////////
	// Bus FSM and PC

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cpu_pkg::FETCH_IDLE;
			pc <= PC_START;
			valid_q <= 1'b0;
		end else begin
			valid_q <= xfer_done;
			case (state)
				cpu_pkg::FETCH_IDLE: begin
					if (run)
						state <= cpu_pkg::FETCH_BUSY;
				end
				cpu_pkg::FETCH_BUSY: begin
					if (xfer_done) begin
						pc <= pc_inc;
						if (!run)
							state <= cpu_pkg::FETCH_IDLE;   // Stop between transfers
					end
				end
				default: state <= cpu_pkg::FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (xfer_done) begin
			instr_q <= wb_dat_i;
			next_pc_q <= cpu_pkg::word_t'(pc_inc);
		end
	end

	assign fetch = '{valid: valid_q, instr: instr_q, next_pc: next_pc_q};

endmodule

/* hw/decode_stage.sv */
module decode_stage (
	input logic clk,
	input logic arst_n,
	input cpu_pkg::fetch_t fetch,
	output cpu_pkg::decoded_t decoded
);

	localparam cpu_pkg::decoded_t NOP_DECODE = '{
		valid: 1'b1,
		alu_op: cpu_pkg::ALU_NONE,
		sel: cpu_pkg::SEL_NONE,
		reg_a: cpu_pkg::REG_NONE,
		reg_b: cpu_pkg::REG_NONE,
		imm: '0,
		reg_write: 1'b0,
		dest: cpu_pkg::REG_NONE
	};

	cpu_pkg::word_t instr;
	cpu_pkg::op_major_e major;
	cpu_pkg::reg_addr_t rx;
	cpu_pkg::reg_addr_t ry;
	cpu_pkg::reg_addr_t rz;
	cpu_pkg::word_t imm_s8;
	cpu_pkg::word_t imm_s4;
	cpu_pkg::word_t imm_z8;
	cpu_pkg::word_t shamt;
	cpu_pkg::decoded_t dec;
	cpu_pkg::decoded_t payload_q;
	logic valid_q;

	// One register-writing operation
	function automatic cpu_pkg::decoded_t make_op(
		input cpu_pkg::alu_op_e op,
		input cpu_pkg::operand_sel_e sel,
		input cpu_pkg::reg_addr_t reg_a,
		input cpu_pkg::reg_addr_t reg_b,
		input cpu_pkg::word_t imm,
		input cpu_pkg::reg_addr_t dest
	);
		cpu_pkg::decoded_t d;
		d.valid = 1'b1;
		d.alu_op = op;
		d.sel = sel;
		d.reg_a = reg_a;
		d.reg_b = reg_b;
		d.imm = imm;
		d.reg_write = 1'b1;
		d.dest = dest;
		return d;
	endfunction

	assign instr = fetch.instr;
	assign major = cpu_pkg::op_major_e'(instr[15:11]);
	assign rx = {1'b0, instr[10:8]};
	assign ry = {1'b0, instr[7:5]};
	assign rz = {1'b0, instr[4:2]};
	assign imm_s8 = {{8{instr[7]}}, instr[7:0]};
	assign imm_s4 = {{12{instr[3]}}, instr[3:0]};
	assign imm_z8 = {8'h00, instr[7:0]};
	assign shamt = (instr[4:2] == 3'b000) ? 16'd8 : {13'd0, instr[4:2]};   // 0 means 8

	////////////////////////////////////////////////////////////////////
	// Instruction decode

	always_comb begin
		dec = NOP_DECODE;                       // Unknown encodings fall through as NOP
		case (major)
			cpu_pkg::OP_ADDIU:
				dec = make_op(cpu_pkg::ALU_ADD, cpu_pkg::SEL_REG_IMM, rx,
					cpu_pkg::REG_NONE, imm_s8, rx);
			cpu_pkg::OP_ADDIU3:
				dec = make_op(cpu_pkg::ALU_ADD, cpu_pkg::SEL_REG_IMM, rx,
					cpu_pkg::REG_NONE, imm_s4, ry);
			cpu_pkg::OP_SP: begin
				if (instr[10:8] == cpu_pkg::FN_ADDSP)
					dec = make_op(cpu_pkg::ALU_ADD, cpu_pkg::SEL_REG_IMM, cpu_pkg::REG_SP,
						cpu_pkg::REG_NONE, imm_s8, cpu_pkg::REG_SP);
				else if (instr[10:8] == cpu_pkg::FN_MTSP)
					dec = make_op(cpu_pkg::ALU_MOVE, cpu_pkg::SEL_REG, ry,
						cpu_pkg::REG_NONE, '0, cpu_pkg::REG_SP);
			end
			cpu_pkg::OP_ADDSUBU: begin
				if (instr[1:0] == cpu_pkg::FN_ADDU)
					dec = make_op(cpu_pkg::ALU_ADD, cpu_pkg::SEL_REG_REG, rx, ry, '0, rz);
				else if (instr[1:0] == cpu_pkg::FN_SUBU)
					dec = make_op(cpu_pkg::ALU_SUB, cpu_pkg::SEL_REG_REG, rx, ry, '0, rz);
			end
			cpu_pkg::OP_RR: begin
				case (instr[4:0])
					cpu_pkg::FN_AND:
						dec = make_op(cpu_pkg::ALU_AND, cpu_pkg::SEL_REG_REG, rx, ry, '0, rx);
					cpu_pkg::FN_OR:
						dec = make_op(cpu_pkg::ALU_OR, cpu_pkg::SEL_REG_REG, rx, ry, '0, rx);
					cpu_pkg::FN_CMP:
						dec = make_op(cpu_pkg::ALU_EQUAL, cpu_pkg::SEL_REG_REG, rx, ry, '0,
							cpu_pkg::REG_T);
					cpu_pkg::FN_PC_GRP: begin
						if (instr[7:5] == cpu_pkg::FN_MFPC)   // JR shares this group
							dec = make_op(cpu_pkg::ALU_MOVE, cpu_pkg::SEL_IMM, cpu_pkg::REG_NONE,
								cpu_pkg::REG_NONE, fetch.next_pc, rx);
					end
					default: ;
				endcase
			end
			cpu_pkg::OP_LI:
				dec = make_op(cpu_pkg::ALU_MOVE, cpu_pkg::SEL_IMM, cpu_pkg::REG_NONE,
					cpu_pkg::REG_NONE, imm_z8, rx);
			cpu_pkg::OP_CMPI:
				dec = make_op(cpu_pkg::ALU_EQUAL, cpu_pkg::SEL_REG_IMM, rx,
					cpu_pkg::REG_NONE, imm_s8, cpu_pkg::REG_T);
			cpu_pkg::OP_IH: begin
				if (instr[0] == cpu_pkg::FN_MFIH)
					dec = make_op(cpu_pkg::ALU_MOVE, cpu_pkg::SEL_REG, cpu_pkg::REG_IH,
						cpu_pkg::REG_NONE, '0, rx);
				else
					dec = make_op(cpu_pkg::ALU_MOVE, cpu_pkg::SEL_REG, rx,
						cpu_pkg::REG_NONE, '0, cpu_pkg::REG_IH);
			end
			cpu_pkg::OP_SHIFT: begin
				if (instr[1:0] == cpu_pkg::FN_SLL)
					dec = make_op(cpu_pkg::ALU_SLL, cpu_pkg::SEL_REG_IMM, ry,
						cpu_pkg::REG_NONE, shamt, rx);
				else if (instr[1:0] == cpu_pkg::FN_SRA)
					dec = make_op(cpu_pkg::ALU_SRA, cpu_pkg::SEL_REG_IMM, ry,
						cpu_pkg::REG_NONE, shamt, rx);
			end
			default: ;                          // NOP and dropped opcodes
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= fetch.valid;
	end

	always_ff @(posedge clk) begin
		if (fetch.valid)
			payload_q <= dec;
	end

	always_comb begin
		decoded = payload_q;
		decoded.valid = valid_q;
	end

endmodule

/* hw/reg_file.sv */
module reg_file (
	input logic clk,
	input logic arst_n,
	input cpu_pkg::reg_addr_t rd_a_addr,
	input cpu_pkg::reg_addr_t rd_b_addr,
	output cpu_pkg::word_t rd_a_data,
	output cpu_pkg::word_t rd_b_data,
	input logic wr_en,
	input cpu_pkg::reg_addr_t wr_addr,
	input cpu_pkg::word_t wr_data
);

	cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

	// Unimplemented indexes read as zero
	assign rd_a_data = (rd_a_addr < cpu_pkg::REG_COUNT) ? regs[rd_a_addr] : '0;
	assign rd_b_data = (rd_b_addr < cpu_pkg::REG_COUNT) ? regs[rd_b_addr] : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < int'(cpu_pkg::REG_COUNT); i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_addr < cpu_pkg::REG_COUNT)) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

/* hw/execute_stage.sv */
module execute_stage (
	input logic clk,
	input logic arst_n,
	input cpu_pkg::decoded_t decoded,
	output cpu_pkg::retire_t retire
);

	cpu_pkg::word_t rd_a_data;
	cpu_pkg::word_t rd_b_data;
	cpu_pkg::word_t op_a;
	cpu_pkg::word_t op_b;
	cpu_pkg::word_t result;
	logic wr_en;
	logic ret_valid_q;
	cpu_pkg::reg_addr_t ret_dest_q;
	cpu_pkg::word_t ret_data_q;

	reg_file reg_file_i (
		.clk(clk),
		.arst_n(arst_n),
		.rd_a_addr(decoded.reg_a),
		.rd_b_addr(decoded.reg_b),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.wr_en(wr_en),
		.wr_addr(decoded.dest),
		.wr_data(result)
	);

	assign wr_en = decoded.valid && decoded.reg_write;

	////////////////////////////////////////////////////////////////////
	// Operands and ALU

	assign op_a = (decoded.sel == cpu_pkg::SEL_IMM) ? decoded.imm : rd_a_data;
	assign op_b = (decoded.sel == cpu_pkg::SEL_REG_REG) ? rd_b_data : decoded.imm;

	always_comb begin
		case (decoded.alu_op)
			cpu_pkg::ALU_ADD: result = op_a + op_b;
			cpu_pkg::ALU_SUB: result = op_a - op_b;
			cpu_pkg::ALU_AND: result = op_a & op_b;
			cpu_pkg::ALU_OR: result = op_a | op_b;
			cpu_pkg::ALU_SLL: result = op_a << op_b[3:0];
			cpu_pkg::ALU_SRA: result = cpu_pkg::word_t'($signed(op_a) >>> op_b[3:0]);
			cpu_pkg::ALU_EQUAL: result = (op_a == op_b) ? 16'd0 : 16'd1;   // T is 0 on match
			cpu_pkg::ALU_MOVE: result = op_a;
			default: result = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// Retire report

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ret_valid_q <= 1'b0;
		else
			ret_valid_q <= wr_en;
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			ret_dest_q <= decoded.dest;
			ret_data_q <= result;
		end
	end

	assign retire = '{valid: ret_valid_q, dest: ret_dest_q, data: ret_data_q};

endmodule

/* hw/cpu_core.sv */
module cpu_core #(
	parameter int WB_ADDR_WIDTH = 16,
	parameter int unsigned RESET_PC = 0
) (
	input logic clk,
	input logic arst_n,
	input logic run,
	output logic wb_cyc,
	output logic wb_stb,
	output logic [WB_ADDR_WIDTH-1:0] wb_adr,
	input cpu_pkg::word_t wb_dat_i,
	input logic wb_ack,
	output cpu_pkg::retire_t retire
);

	cpu_pkg::fetch_t fetch;
	cpu_pkg::decoded_t decoded;

	fetch_stage #(
		.WB_ADDR_WIDTH(WB_ADDR_WIDTH),
		.RESET_PC(RESET_PC)
	) fetch_stage_i (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.fetch(fetch)
	);

	decode_stage decode_stage_i (
		.clk(clk),
		.arst_n(arst_n),
		.fetch(fetch),
		.decoded(decoded)
	);

	execute_stage execute_stage_i (
		.clk(clk),
		.arst_n(arst_n),
		.decoded(decoded),
		.retire(retire)
	);

endmodule

/* dv/cpu_core_asserts.sv */
module cpu_core_asserts #(
	parameter int WB_ADDR_WIDTH = 16
) (
	input logic clk,
	input logic arst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic [WB_ADDR_WIDTH-1:0] wb_adr,
	input logic wb_ack,
	input cpu_pkg::retire_t retire
);

	////////////////////////////////////////////////////////////////////
	// Wishbone classic master

	stb_needs_cyc: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb |-> wb_cyc)
		else $error("wb_stb high without wb_cyc");

	adr_held: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_stb && !wb_ack) |=> $stable(wb_adr))
		else $error("wb_adr changed before wb_ack");

	////////////////////////////////////////////////////////////////////
	// Retire port

	retire_dest_ok: assert property (@(posedge clk) disable iff (!arst_n)
		retire.valid |-> (retire.dest < cpu_pkg::REG_COUNT))
		else $error("retire to an unimplemented register");

	// Two quiet cycles right after reset release
	retire_quiet: assert property (@(posedge clk)
		(arst_n && (!$past(arst_n) || !$past(arst_n, 2))) |-> !retire.valid)
		else $error("retire too soon after reset");

endmodule

bind cpu_core cpu_core_asserts #(
	.WB_ADDR_WIDTH(WB_ADDR_WIDTH)
) cpu_core_asserts_i (
	.clk(clk),
	.arst_n(arst_n),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_adr(wb_adr),
	.wb_ack(wb_ack),
	.retire(retire)
);

/* dv/tb_cpu_core.sv */
module tb_cpu_core;

	localparam int WB_ADDR_WIDTH = 16;
	localparam int unsigned RESET_PC = 16;
	localparam int TIMEOUT = 40;               // Cycles per wait
	localparam cpu_pkg::word_t NOP_WORD = 16'h0800;

	logic clk = 1'b0;
	logic arst_n;
	logic run;
	logic wb_cyc;
	logic wb_stb;
	logic [WB_ADDR_WIDTH-1:0] wb_adr;
	cpu_pkg::word_t wb_dat_i = '0;
	logic wb_ack = 1'b0;
	cpu_pkg::retire_t retire;

	cpu_pkg::word_t prog[$];
	cpu_pkg::word_t model_regs [cpu_pkg::REG_COUNT];
	cpu_pkg::reg_addr_t exp_dest[$];
	cpu_pkg::word_t exp_data[$];
	logic [15:0] lfsr = 16'd72;
	int max_wait;
	int wait_left = 0;
	logic wait_drawn = 1'b0;
	int errors;
	int checks;

	cpu_core #(
		.WB_ADDR_WIDTH(WB_ADDR_WIDTH),
		.RESET_PC(RESET_PC)
	) cpu_core_i (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.retire(retire)
	);

	always #20 clk = ~clk;

	function automatic logic lfsr_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	function automatic cpu_pkg::word_t fetch_word(input logic [WB_ADDR_WIDTH-1:0] adr);
		int idx;
		idx = int'(adr) - int'(RESET_PC);
		if (idx >= 0 && idx < prog.size())
			return prog[idx];
		return NOP_WORD;                        // Past the program end
	endfunction

	////////////////////////////////////////////////////////////////////
	// Wishbone slave with random wait states

	always @(negedge clk) begin
		wb_ack = 1'b0;
		if (!arst_n) begin
			wait_drawn = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!wait_drawn) begin
				wait_left = (max_wait > 0) ? int'(random_bits(2)) : 0;
				wait_drawn = 1'b1;
			end
			if (wait_left == 0) begin
				wb_ack = 1'b1;
				wb_dat_i = fetch_word(wb_adr);
				wait_drawn = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	task automatic check_word(input string what, input cpu_pkg::word_t got,
		input cpu_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input string what, input cpu_pkg::reg_addr_t got,
		input cpu_pkg::reg_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	function automatic cpu_pkg::word_t fields_word(input logic [4:0] op, input logic [2:0] a,
		input logic [2:0] b, input logic [4:0] low);
		return {op, a, b, low};
	endfunction

	function automatic cpu_pkg::word_t imm_word(input logic [4:0] op, input logic [2:0] a,
		input logic [7:0] imm);
		return {op, a, imm};
	endfunction

	task automatic new_program();
		prog.delete();
		exp_dest.delete();
		exp_data.delete();
		foreach (model_regs[i])
			model_regs[i] = '0;
	endtask

	////////////////////////////////////////////////////////////////////
	// Reference model applied as each instruction is added

	task automatic add_instr(input cpu_pkg::word_t w);
		cpu_pkg::reg_addr_t x;
		cpu_pkg::reg_addr_t y;
		cpu_pkg::reg_addr_t d;
		cpu_pkg::word_t s8;
		cpu_pkg::word_t sa;
		cpu_pkg::word_t pc_next;
		cpu_pkg::word_t v;
		logic wr;
		x = {1'b0, w[10:8]};
		y = {1'b0, w[7:5]};
		s8 = {{8{w[7]}}, w[7:0]};
		sa = (w[4:2] == 3'd0) ? 16'd8 : 16'(w[4:2]);
		pc_next = cpu_pkg::word_t'(RESET_PC + prog.size() + 1);
		wr = 1'b1;
		d = x;
		v = '0;
		case (w[15:11])
			cpu_pkg::OP_ADDIU: v = model_regs[x] + s8;
			cpu_pkg::OP_ADDIU3: begin
				d = y;
				v = model_regs[x] + {{12{w[3]}}, w[3:0]};
			end
			cpu_pkg::OP_LI: v = {8'h00, w[7:0]};
			cpu_pkg::OP_CMPI: begin
				d = cpu_pkg::REG_T;
				v = (model_regs[x] == s8) ? 16'd0 : 16'd1;
			end
			cpu_pkg::OP_SP: begin
				d = cpu_pkg::REG_SP;
				if (w[10:8] == 3'b011)
					v = model_regs[cpu_pkg::REG_SP] + s8;
				else if (w[10:8] == 3'b100)
					v = model_regs[y];
				else
					wr = 1'b0;
			end
			cpu_pkg::OP_ADDSUBU: begin
				d = {1'b0, w[4:2]};
				if (w[1:0] == 2'b01)
					v = model_regs[x] + model_regs[y];
				else if (w[1:0] == 2'b11)
					v = model_regs[x] - model_regs[y];
				else
					wr = 1'b0;
			end
			cpu_pkg::OP_RR: begin
				if (w[4:0] == 5'b01100)
					v = model_regs[x] & model_regs[y];
				else if (w[4:0] == 5'b01101)
					v = model_regs[x] | model_regs[y];
				else if (w[4:0] == 5'b01010) begin
					d = cpu_pkg::REG_T;
					v = (model_regs[x] == model_regs[y]) ? 16'd0 : 16'd1;
				end else if (w[4:0] == 5'b00000 && w[7:5] == 3'b010)
					v = pc_next;                // MFPC
				else
					wr = 1'b0;
			end
			cpu_pkg::OP_IH: begin
				if (w[0]) begin
					d = cpu_pkg::REG_IH;
					v = model_regs[x];
				end else begin
					v = model_regs[cpu_pkg::REG_IH];
				end
			end
			cpu_pkg::OP_SHIFT: begin
				if (w[1:0] == 2'b00)
					v = model_regs[y] << sa;
				else if (w[1:0] == 2'b11)
					v = (model_regs[y] >> sa) | ({16{model_regs[y][15]}} & ~(16'hFFFF >> sa));
				else
					wr = 1'b0;
			end
			default: wr = 1'b0;                 // NOP and dropped encodings
		endcase
		if (wr) begin
			model_regs[d] = v;
			exp_dest.push_back(d);
			exp_data.push_back(v);
		end
		prog.push_back(w);
	endtask

	task automatic reset_dut();
		@(negedge clk);
		run = 1'b0;
		arst_n = 1'b0;
		repeat (3) begin
			@(negedge clk);
			if (wb_cyc || wb_stb || retire.valid)
				report_failure("bus or retire active during reset");
		end
		arst_n = 1'b1;
	endtask

	task automatic run_program(input string name);
		int idle;
		cpu_pkg::reg_addr_t d;
		cpu_pkg::word_t v;
		reset_dut();
		@(negedge clk);
		run = 1'b1;
		idle = 0;
		while (!wb_cyc && idle < TIMEOUT) begin
			@(negedge clk);
			idle++;
		end
		if (!wb_cyc)
			report_failure({name, ": fetch never started"});
		else
			check_word({name, " first fetch address"}, wb_adr, cpu_pkg::word_t'(RESET_PC));
		idle = 0;
		while (exp_dest.size() > 0 && idle < TIMEOUT) begin
			@(negedge clk);
			if (retire.valid) begin
				d = exp_dest.pop_front();
				v = exp_data.pop_front();
				check_reg({name, " retire dest"}, retire.dest, d);
				check_word({name, " retire data"}, retire.data, v);
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (exp_dest.size() > 0)
			report_failure({name, ": timed out waiting for a retire"});
		run = 1'b0;
		idle = 0;
		while ((wb_cyc || idle < 6) && idle < TIMEOUT) begin   // Drain until fetch stops
			@(negedge clk);
			if (retire.valid)
				report_failure({name, ": retire past the end of the program"});
			idle++;
		end
		if (wb_cyc)
			report_failure({name, ": fetch did not stop after run fell"});
	endtask

	////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic reset_and_idle();
		new_program();
		reset_dut();
		repeat (5) begin
			@(negedge clk);
			if (wb_cyc || wb_stb || retire.valid)
				report_failure("bus or retire active while run is low");
		end
		add_instr(imm_word(cpu_pkg::OP_LI, 3'd7, 8'h5A));
		run_program("reset and idle");
	endtask

	task automatic immediate_arith();
		new_program();
		add_instr(imm_word(cpu_pkg::OP_LI, 3'd1, 8'h7F));
		add_instr(imm_word(cpu_pkg::OP_ADDIU, 3'd1, 8'hFD));
		add_instr(imm_word(cpu_pkg::OP_ADDIU, 3'd1, 8'h05));
		add_instr(imm_word(cpu_pkg::OP_LI, 3'd2, 8'h80));            // Zero-extended
		add_instr(fields_word(cpu_pkg::OP_ADDIU3, 3'd2, 3'd3, 5'h0F));
		add_instr(fields_word(cpu_pkg::OP_ADDIU3, 3'd1, 3'd4, 5'h07));
		add_instr(imm_word(cpu_pkg::OP_ADDIU, 3'd2, 8'h80));
		run_program("immediate arithmetic");
	endtask

	task automatic register_ops();
		new_program();
		for (int i = 0; i < 3; i++) begin
			add_instr(imm_word(cpu_pkg::OP_LI, 3'd1, random_bits(8)));
			add_instr(imm_word(cpu_pkg::OP_LI, 3'd2, random_bits(8)));
			add_instr(fields_word(cpu_pkg::OP_ADDSUBU, 3'd1, 3'd2, {3'd3, 2'b01}));
			add_instr(fields_word(cpu_pkg::OP_ADDSUBU, 3'd3, 3'd1, {3'd4, 2'b11}));
			add_instr(fields_word(cpu_pkg::OP_RR, 3'd4, 3'd2, 5'b01100));   // AND
			add_instr(fields_word(cpu_pkg::OP_RR, 3'd4, 3'd3, 5'b01101));   // OR
			add_instr(fields_word(cpu_pkg::OP_ADDSUBU, 3'd4, 3'd1, {3'd5, 2'b11}));
		end
		run_program("register operations");
	endtask

	task automatic shifts_and_compares();
		new_program();
		add_instr(imm_word(cpu_pkg::OP_LI, 3'd1, 8'h81));
		add_instr(fields_word(cpu_pkg::OP_SHIFT, 3'd2, 3'd1, {3'd0, 2'b00}));
		for (int s = 0; s < 8; s++) begin
			add_instr(fields_word(cpu_pkg::OP_SHIFT, 3'd3, 3'd2, {3'(s), 2'b11}));
			add_instr(fields_word(cpu_pkg::OP_SHIFT, 3'd4, 3'd1, {3'(s), 2'b00}));
		end
		add_instr(fields_word(cpu_pkg::OP_RR, 3'd1, 3'd1, 5'b01010));
		add_instr(fields_word(cpu_pkg::OP_RR, 3'd1, 3'd2, 5'b01010));
		add_instr(imm_word(cpu_pkg::OP_CMPI, 3'd1, 8'h81));
		add_instr(imm_word(cpu_pkg::OP_LI, 3'd6, 8'h00));
		add_instr(imm_word(cpu_pkg::OP_ADDIU, 3'd6, 8'hF0));
		add_instr(imm_word(cpu_pkg::OP_CMPI, 3'd6, 8'hF0));
		run_program("shifts and compares");
	endtask

	task automatic special_registers();
		new_program();
		add_instr(imm_word(cpu_pkg::OP_SP, 3'b011, 8'h10));         // ADDSP
		add_instr(imm_word(cpu_pkg::OP_SP, 3'b011, 8'hFF));
		add_instr(imm_word(cpu_pkg::OP_LI, 3'd1, 8'h33));
		add_instr(fields_word(cpu_pkg::OP_SP, 3'b100, 3'd1, 5'd0));  // MTSP
		add_instr(imm_word(cpu_pkg::OP_SP, 3'b011, 8'h02));
		add_instr(fields_word(cpu_pkg::OP_IH, 3'd1, 3'd0, 5'd1));    // MTIH
		add_instr(fields_word(cpu_pkg::OP_IH, 3'd2, 3'd0, 5'd0));    // MFIH
		add_instr(fields_word(cpu_pkg::OP_RR, 3'd6, 3'b010, 5'd0));  // MFPC
		add_instr(fields_word(cpu_pkg::OP_RR, 3'd7, 3'b010, 5'd0));
		run_program("special registers");
	endtask

	task automatic wait_states_and_unknowns();
		new_program();
		max_wait = 3;
		for (int i = 0; i < 4; i++) begin
			add_instr(imm_word(cpu_pkg::OP_LI, 3'd1, random_bits(8)));
			add_instr(NOP_WORD);
			add_instr(imm_word(5'b00010, 3'd0, 8'h05));                // B
			add_instr(fields_word(cpu_pkg::OP_ADDSUBU, 3'd1, 3'd2, {3'd2, 2'b01}));
			add_instr(imm_word(5'b10011, 3'd1, 8'h24));                // LW
			add_instr(imm_word(5'b00100, 3'd2, 8'h03));                // BEQZ
			add_instr(imm_word(cpu_pkg::OP_ADDIU, 3'd2, random_bits(8)));
		end
		run_program("wait states");
		max_wait = 0;
	endtask

	initial begin
		arst_n = 1'b0;
		run = 1'b0;
		max_wait = 0;
		errors = 0;
		checks = 0;
		reset_and_idle();
		immediate_arith();
		register_ops();
		shifts_and_compares();
		special_registers();
		wait_states_and_unknowns();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* files.f */
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/cpu_core.sv
dv/cpu_core_asserts.sv
dv/tb_cpu_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cpu_core
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

# The simulation passes only if the pass line shows up in its output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
